//--- verilog/accel_pkg.sv
package accel_pkg;
	localparam int N_LANES = 4;
	localparam int DATA_W = 8;
	localparam int ACT_WORD_W = N_LANES * DATA_W;
	localparam int WBLOCK_W = N_LANES * ACT_WORD_W; // Four rows of four weights
	localparam int ACC_W = 18;
	localparam int LANE_SEL_W = 2;
	localparam int ACT_DEPTH = 256;
	localparam int ACT_ADDR_W = 8;
	localparam int WGT_DEPTH = 256;
	localparam int WGT_ADDR_W = 8;
	localparam int IM_DEPTH = 64;
	localparam int PC_W = 6;
	localparam int SHIFT_W = 3;
	localparam int SAT_MAX = 127;
	localparam int SAT_MIN = -128;
	localparam logic [1:0] PIPE_DRAIN = 2'd2; // Extra DRAIN cycles until write-back
	typedef logic [N_LANES-1:0][DATA_W-1:0] act_word_t;
	typedef logic [N_LANES-1:0][ACC_W-1:0] acc_vec_t;
endpackage

//--- verilog/isa_pkg.sv
package isa_pkg;
	localparam int INSTR_W = 32;

	typedef enum logic [1:0] {
		OP_NOP = 2'd0,
		OP_FC = 2'd1,
		OP_LAYER_END = 2'd2,
		OP_HALT = 2'd3
	} opcode_e;

	// Instruction field positions
	localparam int OPC_LSB = 30;
	localparam int WR_L2_BIT = 29;
	localparam int WR_L1_BIT = 28;
	localparam int RELU_BIT = 27;
	localparam int SHIFT_LSB = 24;
	localparam int IN_ADDR_LSB = 16;
	localparam int WGT_ADDR_LSB = 8;
	localparam int OUT_ADDR_LSB = 0;

	typedef enum logic [1:0] {
		REG_CTRL = 2'd0,
		REG_IMEM = 2'd1,
		REG_ACT = 2'd2,
		REG_WGT = 2'd3
	} region_e; // Host map region in paddr[15:14]

	localparam int REG_IDX_W = 12;
	localparam logic [REG_IDX_W-1:0] CTRL_START_OFS = 12'd0;
	localparam logic [REG_IDX_W-1:0] CTRL_STATUS_OFS = 12'd1;
	localparam int STAT_BUSY_BIT = 0;
	localparam int STAT_FIN_BIT = 1;

	typedef enum logic [1:0] {IDLE, FETCH, ISSUE, DRAIN} ctrl_state_e;
endpackage

//--- verilog/apb_host_port.sv
`timescale 1ns/1ps

module apb_host_port import accel_pkg::*, isa_pkg::*; (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [15:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic im_wr_en,
	output logic [PC_W-1:0] im_wr_addr,
	output logic [INSTR_W-1:0] im_wr_data,
	output logic act_wr_en,
	output logic [ACT_ADDR_W-1:0] act_wr_addr,
	output act_word_t act_wr_data,
	output logic act_rd_en,
	output logic [ACT_ADDR_W-1:0] act_rd_addr,
	input act_word_t act_rd_data,
	output logic wgt_wr_en,
	output logic [WGT_ADDR_W-1:0] wgt_wr_addr,
	output logic [LANE_SEL_W-1:0] wgt_wr_lane,
	output logic [ACT_WORD_W-1:0] wgt_wr_data,
	output logic start,
	output logic [PC_W-1:0] start_pc,
	input logic busy,
	input logic finished_network
);
	region_e region;
	logic [REG_IDX_W-1:0] word_idx;
	logic access;
	logic locked; // Memory region touched while the engine runs
	logic wr_ok;
	logic act_rd_req;
	logic rd_pend;

	assign region = region_e'(paddr[15:14]);
	assign word_idx = paddr[13:2];
	assign access = psel && penable;
	assign locked = (region != REG_CTRL) && busy;
	assign wr_ok = access && pwrite && !locked;
	assign act_rd_req = access && !pwrite && !locked && (region == REG_ACT);

	// First access cycle launches the read, second one returns it
	assign act_rd_en = act_rd_req && !rd_pend;
	assign act_rd_addr = word_idx[ACT_ADDR_W-1:0];
	assign pready = access && !act_rd_en;
	assign pslverr = access && (locked ||
		(!pwrite && (region == REG_IMEM || region == REG_WGT)));

	assign im_wr_en = wr_ok && (region == REG_IMEM);
	assign im_wr_addr = word_idx[PC_W-1:0];
	assign im_wr_data = pwdata;
	assign act_wr_en = wr_ok && (region == REG_ACT);
	assign act_wr_addr = word_idx[ACT_ADDR_W-1:0];
	assign act_wr_data = pwdata;
	assign wgt_wr_en = wr_ok && (region == REG_WGT);
	assign wgt_wr_addr = word_idx[LANE_SEL_W +: WGT_ADDR_W]; // Block index
	assign wgt_wr_lane = word_idx[LANE_SEL_W-1:0]; // Row within block
	assign wgt_wr_data = pwdata;
	assign start = wr_ok && (region == REG_CTRL) && (word_idx == CTRL_START_OFS);
	assign start_pc = pwdata[PC_W-1:0];

	always_ff @(posedge clk) begin
		if (reset)
			rd_pend <= 1'b0;
		else
			rd_pend <= act_rd_en;
	end

	always_comb begin
		prdata = '0;
		if (act_rd_req && rd_pend) begin
			prdata = act_rd_data;
		end else if (access && !pwrite && region == REG_CTRL && word_idx == CTRL_STATUS_OFS) begin
			prdata[STAT_BUSY_BIT] = busy;
			prdata[STAT_FIN_BIT] = finished_network;
		end
	end
endmodule

//--- verilog/instruction_memory.sv
`timescale 1ns/1ps

module instruction_memory import accel_pkg::*, isa_pkg::*; (
	input logic clk,
	input logic wr_en,
	input logic [PC_W-1:0] wr_addr,
	input logic [INSTR_W-1:0] wr_data,
	input logic [PC_W-1:0] rd_addr,
	output logic [INSTR_W-1:0] instr
);
	logic [INSTR_W-1:0] mem [IM_DEPTH];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		instr <= mem[rd_addr]; // Valid in the cycle after fetch
	end
endmodule

//--- verilog/control_unit.sv
`timescale 1ns/1ps

module control_unit import accel_pkg::*, isa_pkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input logic [PC_W-1:0] start_pc,
	output logic busy,
	output logic finished_network,
	output logic done_layer,
	output logic [PC_W-1:0] pc,
	input logic [INSTR_W-1:0] instr,
	output logic act_rd_en,
	output logic [ACT_ADDR_W-1:0] act_rd_addr,
	output logic [WGT_ADDR_W-1:0] wgt_rd_addr,
	output logic issue_valid,
	output logic [SHIFT_W-1:0] issue_shift,
	output logic issue_relu,
	output logic issue_to_l1,
	output logic issue_to_l2,
	output logic [ACT_ADDR_W-1:0] issue_out_addr
);
	ctrl_state_e state;
	opcode_e opcode;
	logic [1:0] drain_cnt;
	logic is_issue;

	assign opcode = opcode_e'(instr[OPC_LSB +: $bits(opcode_e)]);
	assign is_issue = (state == ISSUE);
	assign busy = (state != IDLE);
	assign done_layer = is_issue && (opcode == OP_LAYER_END);

	// Memory reads launch in the issue cycle
	assign act_rd_en = is_issue && (opcode == OP_FC);
	assign act_rd_addr = instr[IN_ADDR_LSB +: ACT_ADDR_W];
	assign wgt_rd_addr = instr[WGT_ADDR_LSB +: WGT_ADDR_W];

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			pc <= '0;
			drain_cnt <= '0;
			finished_network <= 1'b0;
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= 1'b0;
			case (state)
				IDLE: begin
					if (start) begin
						pc <= start_pc;
						finished_network <= 1'b0;
						state <= FETCH;
					end
				end
				FETCH: state <= ISSUE;
				ISSUE: begin
					pc <= pc + 1'b1;
					case (opcode)
						OP_FC: begin
							issue_valid <= 1'b1;
							drain_cnt <= PIPE_DRAIN;
							state <= DRAIN;
						end
						OP_HALT: begin
							finished_network <= 1'b1;
							state <= IDLE;
						end
						default: state <= FETCH; // NOP and layer end
					endcase
				end
				DRAIN: begin
					// Hold off the next fetch until the result is written back
					if (drain_cnt == '0)
						state <= FETCH;
					else
						drain_cnt <= drain_cnt - 1'b1;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Side fields travel one cycle behind, lined up with the read data
	always_ff @(posedge clk) begin
		if (is_issue) begin
			issue_shift <= instr[SHIFT_LSB +: SHIFT_W];
			issue_relu <= instr[RELU_BIT];
			issue_to_l1 <= instr[WR_L1_BIT];
			issue_to_l2 <= instr[WR_L2_BIT];
			issue_out_addr <= instr[OUT_ADDR_LSB +: ACT_ADDR_W];
		end
	end
endmodule

//--- verilog/activation_memory.sv
`timescale 1ns/1ps

module activation_memory import accel_pkg::*; (
	input logic clk,
	input logic host_wr_en,
	input logic [ACT_ADDR_W-1:0] host_wr_addr,
	input act_word_t host_wr_data,
	input logic eng_wr_en,
	input logic [ACT_ADDR_W-1:0] eng_wr_addr,
	input act_word_t eng_wr_data,
	input logic busy,
	input logic eng_rd_en,
	input logic [ACT_ADDR_W-1:0] eng_rd_addr,
	input logic host_rd_en,
	input logic [ACT_ADDR_W-1:0] host_rd_addr,
	output act_word_t rd_data
);
	act_word_t mem [ACT_DEPTH];
	logic wr_en;
	logic [ACT_ADDR_W-1:0] wr_addr;
	act_word_t wr_data;
	logic rd_en;
	logic [ACT_ADDR_W-1:0] rd_addr;

	// Engine owns both ports while running, host otherwise
	assign wr_en = busy ? eng_wr_en : host_wr_en;
	assign wr_addr = busy ? eng_wr_addr : host_wr_addr;
	assign wr_data = busy ? eng_wr_data : host_wr_data;
	assign rd_en = busy ? eng_rd_en : host_rd_en;
	assign rd_addr = busy ? eng_rd_addr : host_rd_addr;

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		if (rd_en)
			rd_data <= mem[rd_addr];
	end
endmodule

//--- verilog/weight_memory.sv
`timescale 1ns/1ps

module weight_memory import accel_pkg::*; (
	input logic clk,
	input logic wr_en,
	input logic [WGT_ADDR_W-1:0] wr_addr,
	input logic [LANE_SEL_W-1:0] wr_lane,
	input logic [ACT_WORD_W-1:0] wr_data,
	input logic [WGT_ADDR_W-1:0] rd_addr,
	output logic [WBLOCK_W-1:0] rd_block
);
	logic [WBLOCK_W-1:0] mem [WGT_DEPTH];

	always_ff @(posedge clk) begin
		// One row of the block per host write
		if (wr_en)
			mem[wr_addr][wr_lane*ACT_WORD_W +: ACT_WORD_W] <= wr_data;
		rd_block <= mem[rd_addr];
	end
endmodule

//--- verilog/mac_array.sv
`timescale 1ns/1ps

module mac_array import accel_pkg::*; (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input act_word_t act_word,
	input logic [WBLOCK_W-1:0] wgt_block,
	input logic [SHIFT_W-1:0] in_shift,
	input logic in_relu,
	input logic in_to_l1,
	input logic in_to_l2,
	input logic [ACT_ADDR_W-1:0] in_out_addr,
	output logic out_valid_acc,
	output acc_vec_t acc,
	output logic [SHIFT_W-1:0] shift,
	output logic relu,
	output logic to_l1,
	output logic to_l2,
	output logic [ACT_ADDR_W-1:0] out_addr
);
	acc_vec_t lane_sum;

	always_comb begin
		logic signed [ACC_W-1:0] sum;
		for (int j = 0; j < N_LANES; j++) begin
			sum = '0;
			// Row j of the block dotted with the input word
			for (int k = 0; k < N_LANES; k++)
				sum = sum + $signed(act_word[k]) *
					$signed(wgt_block[(j*N_LANES + k)*DATA_W +: DATA_W]);
			lane_sum[j] = sum;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			out_valid_acc <= 1'b0;
		else
			out_valid_acc <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			acc <= lane_sum;
			shift <= in_shift;
			relu <= in_relu;
			to_l1 <= in_to_l1;
			to_l2 <= in_to_l2;
			out_addr <= in_out_addr;
		end
	end
endmodule

//--- verilog/output_stage.sv
`timescale 1ns/1ps

module output_stage import accel_pkg::*; (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input acc_vec_t acc,
	input logic [SHIFT_W-1:0] shift,
	input logic relu,
	input logic to_l1,
	input logic to_l2,
	input logic [ACT_ADDR_W-1:0] out_addr,
	output logic l1_wr_en,
	output logic [ACT_ADDR_W-1:0] l1_wr_addr,
	output act_word_t l1_wr_data,
	output logic out_valid,
	output logic [ACT_ADDR_W-1:0] out_addr_l2,
	output logic [ACT_WORD_W-1:0] out_data
);
	act_word_t word_c;
	act_word_t word_q;
	logic [ACT_ADDR_W-1:0] addr_q;

	always_comb begin
		logic signed [ACC_W-1:0] scaled;
		for (int j = 0; j < N_LANES; j++) begin
			scaled = $signed(acc[j]) >>> shift; // Fixed-point rescale
			if (relu && scaled < 0)
				scaled = '0;
			if (scaled > SAT_MAX)
				word_c[j] = DATA_W'(SAT_MAX);
			else if (scaled < SAT_MIN)
				word_c[j] = DATA_W'(SAT_MIN);
			else
				word_c[j] = scaled[DATA_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			l1_wr_en <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			l1_wr_en <= in_valid && to_l1;
			out_valid <= in_valid && to_l2;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			word_q <= word_c;
			addr_q <= out_addr;
		end
	end

	// Same word and address feed both destinations
	assign l1_wr_addr = addr_q;
	assign l1_wr_data = word_q;
	assign out_addr_l2 = addr_q;
	assign out_data = word_q;
endmodule

//--- verilog/cpu.sv
`timescale 1ns/1ps

module cpu import accel_pkg::*, isa_pkg::*; (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [15:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic out_valid,
	output logic [ACT_ADDR_W-1:0] out_addr,
	output logic [ACT_WORD_W-1:0] out_data,
	output logic done_layer,
	output logic finished_network
);
	logic im_wr_en;
	logic [PC_W-1:0] im_wr_addr;
	logic [INSTR_W-1:0] im_wr_data;
	logic act_wr_en;
	logic [ACT_ADDR_W-1:0] act_wr_addr;
	act_word_t act_wr_data;
	logic host_rd_en;
	logic [ACT_ADDR_W-1:0] host_rd_addr;
	act_word_t act_rd_data;
	logic wgt_wr_en;
	logic [WGT_ADDR_W-1:0] wgt_wr_addr;
	logic [LANE_SEL_W-1:0] wgt_wr_lane;
	logic [ACT_WORD_W-1:0] wgt_wr_data;
	logic start;
	logic [PC_W-1:0] start_pc;
	logic busy;
	logic [PC_W-1:0] pc;
	logic [INSTR_W-1:0] instr;
	logic eng_rd_en;
	logic [ACT_ADDR_W-1:0] eng_rd_addr;
	logic [WGT_ADDR_W-1:0] wgt_rd_addr;
	logic [WBLOCK_W-1:0] wgt_block;
	logic issue_valid;
	logic [SHIFT_W-1:0] issue_shift;
	logic issue_relu;
	logic issue_to_l1;
	logic issue_to_l2;
	logic [ACT_ADDR_W-1:0] issue_out_addr;
	logic mac_valid;
	acc_vec_t acc;
	logic [SHIFT_W-1:0] mac_shift;
	logic mac_relu;
	logic mac_to_l1;
	logic mac_to_l2;
	logic [ACT_ADDR_W-1:0] mac_out_addr;
	logic l1_wr_en;
	logic [ACT_ADDR_W-1:0] l1_wr_addr;
	act_word_t l1_wr_data;

	apb_host_port host_port0 (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.im_wr_en(im_wr_en), .im_wr_addr(im_wr_addr), .im_wr_data(im_wr_data),
		.act_wr_en(act_wr_en), .act_wr_addr(act_wr_addr), .act_wr_data(act_wr_data),
		.act_rd_en(host_rd_en), .act_rd_addr(host_rd_addr), .act_rd_data(act_rd_data),
		.wgt_wr_en(wgt_wr_en), .wgt_wr_addr(wgt_wr_addr), .wgt_wr_lane(wgt_wr_lane),
		.wgt_wr_data(wgt_wr_data),
		.start(start), .start_pc(start_pc), .busy(busy), .finished_network(finished_network)
	);

	instruction_memory imem0 (
		.clk(clk), .wr_en(im_wr_en), .wr_addr(im_wr_addr), .wr_data(im_wr_data),
		.rd_addr(pc), .instr(instr)
	);

	control_unit cu0 (
		.clk(clk), .reset(reset), .start(start), .start_pc(start_pc),
		.busy(busy), .finished_network(finished_network), .done_layer(done_layer),
		.pc(pc), .instr(instr),
		.act_rd_en(eng_rd_en), .act_rd_addr(eng_rd_addr), .wgt_rd_addr(wgt_rd_addr),
		.issue_valid(issue_valid), .issue_shift(issue_shift), .issue_relu(issue_relu),
		.issue_to_l1(issue_to_l1), .issue_to_l2(issue_to_l2),
		.issue_out_addr(issue_out_addr)
	);

	activation_memory l1_mem0 (
		.clk(clk),
		.host_wr_en(act_wr_en), .host_wr_addr(act_wr_addr), .host_wr_data(act_wr_data),
		.eng_wr_en(l1_wr_en), .eng_wr_addr(l1_wr_addr), .eng_wr_data(l1_wr_data),
		.busy(busy),
		.eng_rd_en(eng_rd_en), .eng_rd_addr(eng_rd_addr),
		.host_rd_en(host_rd_en), .host_rd_addr(host_rd_addr),
		.rd_data(act_rd_data)
	);

	weight_memory wmem0 (
		.clk(clk), .wr_en(wgt_wr_en), .wr_addr(wgt_wr_addr), .wr_lane(wgt_wr_lane),
		.wr_data(wgt_wr_data), .rd_addr(wgt_rd_addr), .rd_block(wgt_block)
	);

	mac_array mac0 (
		.clk(clk), .reset(reset), .in_valid(issue_valid),
		.act_word(act_rd_data), .wgt_block(wgt_block),
		.in_shift(issue_shift), .in_relu(issue_relu), .in_to_l1(issue_to_l1),
		.in_to_l2(issue_to_l2), .in_out_addr(issue_out_addr),
		.out_valid_acc(mac_valid), .acc(acc), .shift(mac_shift), .relu(mac_relu),
		.to_l1(mac_to_l1), .to_l2(mac_to_l2), .out_addr(mac_out_addr)
	);

	output_stage out0 (
		.clk(clk), .reset(reset), .in_valid(mac_valid), .acc(acc),
		.shift(mac_shift), .relu(mac_relu), .to_l1(mac_to_l1), .to_l2(mac_to_l2),
		.out_addr(mac_out_addr),
		.l1_wr_en(l1_wr_en), .l1_wr_addr(l1_wr_addr), .l1_wr_data(l1_wr_data),
		.out_valid(out_valid), .out_addr_l2(out_addr), .out_data(out_data) // L2 port
	);
endmodule

//--- tb/cpu_sva.sv
`timescale 1ns/1ps

module cpu_sva (
	input logic clk,
	input logic reset,
	input logic pready,
	input logic pslverr,
	input logic done_layer,
	input logic out_valid,
	input logic finished_network
);
	int fail_count = 0; // Assertion failures so far

	// An error response only comes with a completed transfer
	a_slverr_with_ready: assert property (@(posedge clk) disable iff (reset)
		pslverr |-> pready)
		else begin
			fail_count++;
			$error("pslverr high while pready is low");
		end

	a_done_single_cycle: assert property (@(posedge clk) disable iff (reset)
		done_layer |=> !done_layer)
		else begin
			fail_count++;
			$error("done_layer held high for two cycles");
		end

	// Nothing is left in the pipeline once the halt retires
	a_quiet_after_halt: assert property (@(posedge clk) disable iff (reset)
		$rose(finished_network) |=> !out_valid)
		else begin
			fail_count++;
			$error("out_valid high right after finished_network rose");
		end
endmodule

//--- tb/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu import accel_pkg::*, isa_pkg::*; ();
	typedef struct packed {
		opcode_e op;
		logic [7:0] in_a;
		logic [7:0] w_a;
		logic [7:0] out_a;
		logic [2:0] sh;
		logic relu;
		logic l1;
		logic l2;
	} row_t;

	logic clk = 1'b0;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [15:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic out_valid;
	logic [7:0] out_addr;
	logic [31:0] out_data;
	logic done_layer;
	logic finished_network;

	row_t prog[$];
	logic [31:0] l1_model [64];
	logic [127:0] wgt_model [9];
	logic [7:0] exp_addr[$];
	logic [31:0] exp_data[$];
	logic [7:0] obs_addr[$];
	logic [31:0] obs_data[$];
	int layer_rows = 0;
	int layer_pulses = 0;
	logic [31:0] lfsr_state = 32'h0b782f1b;

	cpu dut0 (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.out_valid(out_valid), .out_addr(out_addr), .out_data(out_data),
		.done_layer(done_layer), .finished_network(finished_network)
	);

	bind cpu cpu_sva sva0 (
		.clk(clk), .reset(reset), .pready(pready), .pslverr(pslverr),
		.done_layer(done_layer), .out_valid(out_valid), .finished_network(finished_network)
	);

	always #5 clk = ~clk;

	// L2 port has no back-pressure, so every valid cycle is taken
	always @(negedge clk) begin
		if (!reset) begin
			if (out_valid) begin
				obs_addr.push_back(out_addr);
				obs_data.push_back(out_data);
			end
			if (done_layer)
				layer_pulses++;
		end
	end

	// Protocol checker errors end the run at once
	always @(negedge clk) begin
		if (dut0.sva0.fail_count != 0)
			report_error("Protocol assertion in cpu_sva failed");
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [31:0] encode_row(input row_t r);
		return {r.op, r.l2, r.l1, r.relu, r.sh, r.in_a, r.w_a, r.out_a};
	endfunction

	// Dot product per lane, then shift, ReLU and int8 clamp
	function automatic logic [31:0] expected_word(input logic [31:0] act,
		input logic [127:0] blk, input logic [2:0] sh, input logic relu);
		logic [31:0] word;
		int dot;
		int v;
		int a;
		int b;
		for (int j = 0; j < 4; j++) begin
			dot = 0;
			for (int k = 0; k < 4; k++) begin
				a = $signed(act[k*8 +: 8]);
				b = $signed(blk[(j*4 + k)*8 +: 8]);
				dot += a * b;
			end
			v = dot >>> sh;
			if (relu && v < 0)
				v = 0;
			if (v > 127)
				v = 127;
			else if (v < -128)
				v = -128;
			word[j*8 +: 8] = v[7:0];
		end
		return word;
	endfunction

	function automatic logic [15:0] act_addr(input logic [7:0] a);
		return {REG_ACT, 4'd0, a, 2'b00};
	endfunction

	function automatic logic [15:0] imem_addr(input logic [5:0] pc);
		return {REG_IMEM, 6'd0, pc, 2'b00};
	endfunction

	function automatic logic [15:0] wgt_addr(input logic [7:0] blk, input logic [1:0] row);
		return {REG_WGT, 2'd0, blk, row, 2'b00};
	endfunction

	function automatic logic [15:0] ctrl_addr(input logic [11:0] ofs);
		return {REG_CTRL, ofs, 2'b00};
	endfunction

	task automatic report_error(input string line);
		$display("%s", line);
		$display("STATUS: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else report_error($sformatf("Fail t=%0t %s got 0x%08h expected 0x%08h",
			$time, name, got, exp));
	endtask

	task automatic apb_xfer(input logic wr, input logic [15:0] addr, input logic [31:0] data,
		output logic [31:0] rdata, output logic err);
		int cnt;
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		cnt = 0;
		@(negedge clk);
		while (!pready && cnt < 8) begin
			@(negedge clk);
			cnt++;
		end
		if (!pready)
			report_error($sformatf("APB transfer to 0x%04h never completed", addr));
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic write_word(input logic [15:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic err;
		apb_xfer(1'b1, addr, data, rd, err);
		check_value("pslverr on write", err, 32'h0);
	endtask

	task automatic read_check(input string name, input logic [15:0] addr,
		input logic [31:0] exp_data, input logic exp_err);
		logic [31:0] rd;
		logic err;
		apb_xfer(1'b0, addr, 32'h0, rd, err);
		check_value(name, rd, exp_data);
		check_value({name, " pslverr"}, err, exp_err);
	endtask

	task automatic wait_finished();
		int cnt;
		cnt = 0;
		do begin
			@(negedge clk);
			cnt++;
		end while (!finished_network && cnt < 2000);
		if (!finished_network)
			report_error("Timeout waiting for finished_network after start");
	endtask

	initial begin
		logic [31:0] rd;
		logic err;
		logic [31:0] w;
		logic [5:0] halt_pc;
		row_t r;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		halt_pc = '0;
		// op, input, weight block, output, shift, relu, to L1, to L2
		prog = '{
			'{OP_FC, 8'd0, 8'd0, 8'd40, 3'd0, 1'b0, 1'b0, 1'b1},
			'{OP_FC, 8'd16, 8'd8, 8'd41, 3'd0, 1'b0, 1'b1, 1'b1}, // Both clamp limits
			'{OP_FC, 8'd1, 8'd1, 8'd42, 3'd1, 1'b1, 1'b1, 1'b0},
			'{OP_FC, 8'd42, 8'd2, 8'd43, 3'd2, 1'b0, 1'b1, 1'b1}, // Reads the row above
			'{OP_LAYER_END, 8'd0, 8'd0, 8'd0, 3'd0, 1'b0, 1'b0, 1'b0},
			'{OP_FC, 8'd2, 8'd3, 8'd44, 3'd3, 1'b1, 1'b0, 1'b1},
			'{OP_FC, 8'd3, 8'd4, 8'd45, 3'd4, 1'b0, 1'b1, 1'b1},
			'{OP_NOP, 8'd0, 8'd0, 8'd0, 3'd0, 1'b0, 1'b0, 1'b0},
			'{OP_FC, 8'd45, 8'd5, 8'd46, 3'd5, 1'b1, 1'b1, 1'b1},
			'{OP_FC, 8'd4, 8'd6, 8'd47, 3'd6, 1'b0, 1'b1, 1'b0},
			'{OP_FC, 8'd5, 8'd7, 8'd48, 3'd7, 1'b1, 1'b0, 1'b1},
			'{OP_FC, 8'd16, 8'd8, 8'd49, 3'd7, 1'b1, 1'b1, 1'b1},
			'{OP_LAYER_END, 8'd0, 8'd0, 8'd0, 3'd0, 1'b0, 1'b0, 1'b0},
			'{OP_HALT, 8'd0, 8'd0, 8'd0, 3'd0, 1'b0, 1'b0, 1'b0}
		};
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("out_valid", out_valid, 32'h0);
		check_value("done_layer", done_layer, 32'h0);
		check_value("finished_network", finished_network, 32'h0);
		read_check("status", ctrl_addr(CTRL_STATUS_OFS), 32'h0, 1'b0);

		for (int a = 0; a < 64; a++) begin
			if (a == 16)
				w = 32'h7f7f7f7f; // Saturating input word
			else
				w = lfsr_bits(32);
			l1_model[a] = w;
			write_word(act_addr(8'(a)), w);
		end
		for (int b = 0; b < 9; b++) begin
			for (int j = 0; j < 4; j++) begin
				if (b == 8 && j < 2)
					w = (j == 0) ? 32'h7f7f7f7f : 32'h81818181;
				else
					w = lfsr_bits(32);
				wgt_model[b][j*32 +: 32] = w;
				write_word(wgt_addr(8'(b), 2'(j)), w);
			end
		end
		for (int a = 0; a < 4; a++)
			read_check("act prdata", act_addr(8'(a)), l1_model[a], 1'b0);
		read_check("imem prdata", imem_addr(6'd0), 32'h0, 1'b1);

		for (int i = 0; i < prog.size(); i++) begin
			r = prog[i];
			write_word(imem_addr(6'(i)), encode_row(r));
			case (r.op)
				OP_FC: begin
					w = expected_word(l1_model[r.in_a], wgt_model[r.w_a], r.sh, r.relu);
					if (r.l1)
						l1_model[r.out_a] = w;
					if (r.l2) begin
						exp_addr.push_back(r.out_a);
						exp_data.push_back(w);
					end
				end
				OP_LAYER_END: layer_rows++;
				OP_HALT: halt_pc = 6'(i);
				default: ;
			endcase
		end

		write_word(ctrl_addr(CTRL_START_OFS), 32'h0);
		apb_xfer(1'b1, act_addr(8'd60), ~l1_model[60], rd, err); // Engine still running
		check_value("pslverr while busy", err, 32'h1);
		wait_finished();
		read_check("status", ctrl_addr(CTRL_STATUS_OFS), 32'h2, 1'b0);

		check_value("out_valid count", obs_data.size(), exp_data.size());
		for (int i = 0; i < exp_data.size(); i++) begin
			check_value($sformatf("out_addr[%0d]", i), obs_addr[i], exp_addr[i]);
			check_value($sformatf("out_data[%0d]", i), obs_data[i], exp_data[i]);
		end
		check_value("done_layer pulses", layer_pulses, layer_rows);
		for (int a = 0; a < 64; a++)
			read_check($sformatf("L1 word %0d", a), act_addr(8'(a)), l1_model[a], 1'b0);

		// Second run only executes the halt
		write_word(ctrl_addr(CTRL_START_OFS), 32'(halt_pc));
		@(negedge clk);
		check_value("finished_network after start", finished_network, 32'h0);
		wait_finished();

		if (dut0.sva0.fail_count != 0)
			report_error("Protocol assertions in cpu_sva failed during the run");
		else begin
			$display("STATUS: PASS");
			$finish;
		end
	end
endmodule

//--- sources.f
verilog/accel_pkg.sv
verilog/isa_pkg.sv
verilog/apb_host_port.sv
verilog/instruction_memory.sv
verilog/control_unit.sv
verilog/activation_memory.sv
verilog/weight_memory.sv
verilog/mac_array.sv
verilog/output_stage.sv
verilog/cpu.sv
tb/cpu_sva.sv
tb/tb_cpu.sv
